// File: nnLayer.f
+incdir+common
+incdir+verif
common/nnPkg.sv
design/fpMul.sv
design/fpAdd.sv
neuron/neuronNode.sv
design/apbRegs.sv
design/nnLayer.sv
verif/nnTb.sv

// File: Bender.yml
package:
  name: nnLayer

sources:
  - include_dirs:
      - common
    files:
      - common/nnPkg.sv
      - design/fpMul.sv
      - design/fpAdd.sv
      - neuron/neuronNode.sv
      - design/apbRegs.sv
      - design/nnLayer.sv
  - target: simulation
    include_dirs:
      - common
      - verif
    files:
      - verif/nnTb.sv

// File: verif/nnTbApb.svh
`ifndef NN_TB_APB_SVH
`define NN_TB_APB_SVH

// 32-bit Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsrNext(input logic [31:0] state);
	return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

function automatic logic [31:0] randBits(input int n);
	logic [31:0] val;
	val = '0;
	for (int i = 0; i < n; i++)
	begin
		lfsrState = lfsrNext(lfsrState); // one step per bit
		val = {val[30:0], lfsrState[0]};
	end
	return val;
endfunction

function automatic int randSmall();
	return int'(randBits(4) % 9) - 4; // -4 to 4
endfunction

function automatic int randPos();
	return int'(randBits(2)) + 1;
endfunction

function automatic int randExp();
	return int'(randBits(4)) - 8;
endfunction

task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, input logic errExp);
	@(posedge clk);
	paddr <= addr;
	pwdata <= data;
	pwrite <= 1'b1;
	psel <= 1'b1;
	penable <= 1'b0;
	expectErr <= errExp;
	@(posedge clk);
	penable <= 1'b1;
	@(posedge clk);
	psel <= 1'b0;
	penable <= 1'b0;
	expectErr <= 1'b0;
endtask

task automatic apbRead(input logic [7:0] addr, input logic errExp, output logic [31:0] data);
	@(posedge clk);
	paddr <= addr;
	pwrite <= 1'b0;
	psel <= 1'b1;
	penable <= 1'b0;
	expectErr <= errExp;
	@(posedge clk);
	penable <= 1'b1;
	@(negedge clk);
	data = prdata; // middle of the access phase
	@(posedge clk);
	psel <= 1'b0;
	penable <= 1'b0;
	expectErr <= 1'b0;
endtask

task automatic apbCheck(input logic [7:0] addr, input logic [31:0] expected, input string name);
	logic [31:0] data;
	apbRead(addr, 1'b0, data);
	checkCount++;
	assert (data === expected)
	else failRun($sformatf("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, data));
endtask

`endif

// File: verif/nnTb.sv
`timescale 1ns/100ps
`include "nn_consts.svh"

module nnTb;
	localparam int clkPeriod = 100;
	localparam int numSteps = 9; // register test and eight layer runs
	localparam int watchdogCycles = 200 * numSteps;
	localparam int maxPolls = 40;
	localparam int numRegs = 29;
	localparam int idxW0 = 8;
	localparam int idxW1 = 16;
	localparam int idxWout = 24;
	localparam int idxB0 = 26;
	localparam int idxB1 = 27;
	localparam int idxBout = 28;
	localparam int expectedChecks = 45;

	logic clk;
	logic rstN;
	logic [`NN_ADDR_W-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic expectErr;
	logic [31:0] lfsrState;
	int checkCount;
	int layerInt [numRegs]; // inputs, weights, biases in register order
	logic [31:0] layerF [numRegs];

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	`include "nnTbApb.svh"

	nnLayer nnLayer_inst
	(
		.clk(clk),
		.rstN(rstN),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial
	begin
		#(watchdogCycles * clkPeriod);
		failRun($sformatf("simulation did not finish within %0d cycles", watchdogCycles));
	end

	assert property (@(posedge clk) pready)
	else failRun($sformatf("MISMATCH at %0t: pready expected 1, got %b", $time, $sampled(pready)));

	assert property (@(posedge clk) disable iff (!rstN) pslverr == (psel && penable && expectErr))
	else failRun($sformatf("MISMATCH at %0t: pslverr expected %b, got %b", $time,
		$sampled(psel && penable && expectErr), $sampled(pslverr)));

	function automatic int relu(input int x);
		return (x < 0) ? 0 : x;
	endfunction

	// exact for magnitudes below 2^24
	function automatic logic [31:0] intToFloat(input int v);
		logic [31:0] mag;
		logic [31:0] shifted;
		int msb;
		if (v == 0)
			return 32'd0;
		mag = (v < 0) ? -v : v;
		msb = 0;
		for (int i = 0; i < 31; i++)
			if (mag[i])
				msb = i;
		shifted = mag << (23 - msb);
		return {v < 0, 8'(`NN_EXP_BIAS + msb), shifted[22:0]};
	endfunction

	function automatic logic [31:0] pow2Float(input int e, input logic neg);
		return {neg, 8'(`NN_EXP_BIAS + e), 23'd0};
	endfunction

	function automatic logic [7:0] regAddr(input int i);
		if (i < idxW1 && i >= idxW0)
			return 8'(`NN_ADDR_W0 + 4 * (i - idxW0));
		else if (i < idxW0)
			return 8'(`NN_ADDR_IN + 4 * i);
		else if (i < idxWout)
			return 8'(`NN_ADDR_W1 + 4 * (i - idxW1));
		else if (i < idxB0)
			return 8'(`NN_ADDR_WOUT + 4 * (i - idxWout));
		else if (i == idxB0)
			return `NN_ADDR_B0;
		else if (i == idxB1)
			return `NN_ADDR_B1;
		else
			return `NN_ADDR_BOUT;
	endfunction

	function automatic int layerModel();
		int h0;
		int h1;
		h0 = layerInt[idxB0];
		h1 = layerInt[idxB1];
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			h0 += layerInt[i] * layerInt[idxW0 + i];
			h1 += layerInt[i] * layerInt[idxW1 + i];
		end
		return relu(layerInt[idxWout] * relu(h0) + layerInt[idxWout + 1] * relu(h1) +
			layerInt[idxBout]);
	endfunction

	task automatic convertValues();
		for (int i = 0; i < numRegs; i++)
			layerF[i] = intToFloat(layerInt[i]);
	endtask

	task automatic randomValues();
		do
		begin
			for (int i = 0; i < numRegs; i++)
				layerInt[i] = randSmall();
		end
		while (layerModel() <= 0 || layerModel() == layerInt[idxBout]); // hidden sums must show
		convertValues();
	endtask

	task automatic reluValues(input logic negOut);
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			layerInt[i] = randPos();
			layerInt[idxW0 + i] = -randPos(); // hidden 0 ends below zero
			layerInt[idxW1 + i] = randPos();
		end
		layerInt[idxB0] = -1;
		layerInt[idxB1] = randSmall();
		if (negOut)
		begin
			layerInt[idxWout] = randSmall();
			layerInt[idxWout + 1] = -randPos();
			layerInt[idxBout] = -1;
		end
		else
		begin
			layerInt[idxWout] = 4; // would show any leak from hidden 0
			layerInt[idxWout + 1] = 1;
			layerInt[idxBout] = randSmall();
		end
		convertValues();
	endtask

	task automatic edgeValues(input int e);
		for (int i = 0; i < idxWout; i++)
			layerF[i] = pow2Float(e, 1'b0);
		layerF[idxWout] = intToFloat(1);
		layerF[idxWout + 1] = intToFloat(1);
		layerF[idxB0] = 32'd0;
		layerF[idxB1] = 32'd0;
		layerF[idxBout] = 32'd0;
	endtask

	task automatic writeLayer();
		for (int i = 0; i < numRegs; i++)
			apbWrite(regAddr(i), layerF[i], 1'b0);
	endtask

	task automatic waitDone();
		logic [31:0] status;
		int polls;
		status = '0;
		polls = 0;
		while (!status[1])
		begin
			if (polls == maxPolls)
				failRun($sformatf("layer did not report done within %0d status polls", maxPolls));
			apbRead(`NN_ADDR_STATUS, 1'b0, status);
			polls++;
			assert (!(status[0] && status[1]))
			else failRun($sformatf("MISMATCH at %0t: STATUS done expected 0 while busy, got %b",
				$time, status[1]));
		end
	endtask

	task automatic runLayer(input logic [31:0] expected, input string name);
		writeLayer();
		apbWrite(`NN_ADDR_CTRL, 32'd1, 1'b0);
		waitDone();
		apbCheck(`NN_ADDR_RESULT, expected, name);
	endtask

	task automatic regAccessTest();
		logic [31:0] dummy;
		apbCheck(`NN_ADDR_STATUS, 32'd0, "STATUS after reset");
		apbCheck(`NN_ADDR_RESULT, 32'd0, "RESULT after reset");
		apbCheck(`NN_ADDR_CTRL, 32'd0, "CTRL after reset");
		for (int i = 0; i < numRegs; i++)
		begin
			layerF[i] = pow2Float(randExp(), 1'(randBits(1)));
			apbWrite(regAddr(i), layerF[i], 1'b0);
		end
		for (int i = 0; i < numRegs; i++)
			apbCheck(regAddr(i), layerF[i], $sformatf("register 0x%02h", regAddr(i)));
		apbWrite(`NN_ADDR_RESULT, 32'h1234_5678, 1'b0);
		apbCheck(`NN_ADDR_RESULT, 32'd0, "RESULT after write");
		apbWrite(8'h10, 32'hDEAD_BEEF, 1'b1); // hole in the map
		apbRead(8'hE4, 1'b1, dummy);
		apbRead(8'h42, 1'b1, dummy); // misaligned
	endtask

	task automatic busyTest();
		logic [31:0] firstResult;
		randomValues();
		firstResult = intToFloat(layerModel());
		writeLayer();
		apbWrite(`NN_ADDR_CTRL, 32'd1, 1'b0);
		apbCheck(`NN_ADDR_STATUS, 32'h1, "STATUS busy after start");
		apbWrite(`NN_ADDR_CTRL, 32'd1, 1'b0); // lands while busy
		waitDone();
		apbCheck(`NN_ADDR_RESULT, firstResult, "RESULT after start during busy");
		do
			randomValues();
		while (intToFloat(layerModel()) == firstResult); // second run must differ
		writeLayer();
		apbCheck(`NN_ADDR_STATUS, 32'h2, "STATUS done while idle");
		apbCheck(`NN_ADDR_RESULT, firstResult, "RESULT before second start");
		apbWrite(`NN_ADDR_CTRL, 32'd1, 1'b0);
		apbCheck(`NN_ADDR_STATUS, 32'h1, "STATUS after second start");
		waitDone();
		apbCheck(`NN_ADDR_RESULT, intToFloat(layerModel()), "RESULT of second run");
	endtask

	initial
	begin
		rstN = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		expectErr = 1'b0;
		checkCount = 0;
		lfsrState = 32'd69001;
		repeat (16) @(posedge clk);
		rstN <= 1'b1;

		regAccessTest();
		repeat (2)
		begin
			randomValues();
			runLayer(intToFloat(layerModel()), "RESULT random run");
		end
		reluValues(1'b0);
		runLayer(intToFloat(layerModel()), "RESULT with hidden 0 clipped");
		reluValues(1'b1);
		runLayer(32'd0, "RESULT with negative output sum");
		edgeValues(100);
		runLayer(`NN_FLOAT_MAX, "RESULT on overflow");
		edgeValues(-100);
		runLayer(32'd0, "RESULT on underflow");
		busyTest();

		if (checkCount == expectedChecks)
		begin
			$display("Test passed");
			$finish;
		end
		else
			failRun($sformatf("only %0d of %0d checks ran", checkCount, expectedChecks));
	end

endmodule

// File: design/nnLayer.sv
`timescale 1ns/100ps
`include "nn_consts.svh"

module nnLayer
(
	input logic clk,
	input logic rstN,
	input logic [`NN_ADDR_W-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);
	import nnPkg::*;

	floatT act [`NN_INPUTS];
	floatT weightH0 [`NN_INPUTS];
	floatT weightH1 [`NN_INPUTS];
	floatT weightOut [`NN_HIDDEN];
	floatT biasH0;
	floatT biasH1;
	floatT biasOut;
	floatT hiddenRes [`NN_HIDDEN];
	floatT outResult;
	logic startHidden;
	logic hiddenDone0;
	logic outDone;

	apbRegs regs
	(
		.clk(clk),
		.rstN(rstN),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.act(act),
		.weightH0(weightH0),
		.weightH1(weightH1),
		.weightOut(weightOut),
		.biasH0(biasH0),
		.biasH1(biasH1),
		.biasOut(biasOut),
		.startHidden(startHidden),
		.outDone(outDone),
		.outResult(outResult)
	);

	neuronNode #(.NUM_IN(`NN_INPUTS)) hiddenNode0
	(
		.clk(clk),
		.rstN(rstN),
		.start(startHidden),
		.act(act),
		.weight(weightH0),
		.bias(biasH0),
		.result(hiddenRes[0]),
		.done(hiddenDone0)
	);

	// same latency as node 0, so its done is not needed
	neuronNode #(.NUM_IN(`NN_INPUTS)) hiddenNode1
	(
		.clk(clk),
		.rstN(rstN),
		.start(startHidden),
		.act(act),
		.weight(weightH1),
		.bias(biasH1),
		.result(hiddenRes[1]),
		.done()
	);

	neuronNode #(.NUM_IN(`NN_HIDDEN)) outNode
	(
		.clk(clk),
		.rstN(rstN),
		.start(hiddenDone0),
		.act(hiddenRes),
		.weight(weightOut),
		.bias(biasOut),
		.result(outResult),
		.done(outDone)
	);

endmodule

// File: design/apbRegs.sv
`timescale 1ns/100ps
`include "nn_consts.svh"

module apbRegs
(
	input logic clk,
	input logic rstN,
	input logic [`NN_ADDR_W-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output nnPkg::floatT act [`NN_INPUTS],
	output nnPkg::floatT weightH0 [`NN_INPUTS],
	output nnPkg::floatT weightH1 [`NN_INPUTS],
	output nnPkg::floatT weightOut [`NN_HIDDEN],
	output nnPkg::floatT biasH0,
	output nnPkg::floatT biasH1,
	output nnPkg::floatT biasOut,
	output logic startHidden,
	input logic outDone,
	input nnPkg::floatT outResult
);
	import nnPkg::*;

	localparam logic [`NN_ADDR_W-1:0] blockMask = 8'hE0; // 8-word blocks
	localparam logic [`NN_ADDR_W-1:0] pairMask = 8'hF8; // 2-word block

	logic [31:0] ctrlReg;
	logic busy;
	logic doneFlag;
	floatT resultReg;
	logic selCtrl;
	logic selStatus;
	logic selResult;
	logic selIn;
	logic selW0;
	logic selW1;
	logic selWout;
	logic selB0;
	logic selB1;
	logic selBout;
	logic mapHit;
	logic [31:0] rdData;
	logic wrEn;
	logic startReq;

	always_comb
	begin
		selCtrl = (paddr == `NN_ADDR_CTRL);
		selStatus = (paddr == `NN_ADDR_STATUS);
		selResult = (paddr == `NN_ADDR_RESULT);
		selIn = (paddr[1:0] == 2'b00) && ((paddr & blockMask) == `NN_ADDR_IN);
		selW0 = (paddr[1:0] == 2'b00) && ((paddr & blockMask) == `NN_ADDR_W0);
		selW1 = (paddr[1:0] == 2'b00) && ((paddr & blockMask) == `NN_ADDR_W1);
		selWout = (paddr[1:0] == 2'b00) && ((paddr & pairMask) == `NN_ADDR_WOUT);
		selB0 = (paddr == `NN_ADDR_B0);
		selB1 = (paddr == `NN_ADDR_B1);
		selBout = (paddr == `NN_ADDR_BOUT);
		mapHit = selCtrl | selStatus | selResult | selIn | selW0 | selW1 |
			selWout | selB0 | selB1 | selBout;

		rdData = '0;
		if (selCtrl)
			rdData = ctrlReg;
		else if (selStatus)
			rdData = {30'd0, doneFlag, busy};
		else if (selResult)
			rdData = resultReg;
		else if (selIn)
			rdData = act[paddr[4:2]];
		else if (selW0)
			rdData = weightH0[paddr[4:2]];
		else if (selW1)
			rdData = weightH1[paddr[4:2]];
		else if (selWout)
			rdData = weightOut[paddr[2]];
		else if (selB0)
			rdData = biasH0;
		else if (selB1)
			rdData = biasH1;
		else if (selBout)
			rdData = biasOut;
	end

	assign pready = 1'b1; // no wait states
	assign pslverr = psel && penable && !mapHit;
	assign prdata = (psel && !pwrite) ? rdData : 32'd0;

	assign wrEn = psel && penable && pwrite && mapHit;
	assign startReq = wrEn && selCtrl && pwdata[0] && !busy; // ignored while busy

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			ctrlReg <= '0;
			for (int i = 0; i < `NN_INPUTS; i++)
			begin
				act[i] <= '0;
				weightH0[i] <= '0;
				weightH1[i] <= '0;
			end
			for (int i = 0; i < `NN_HIDDEN; i++)
				weightOut[i] <= '0;
			biasH0 <= '0;
			biasH1 <= '0;
			biasOut <= '0;
		end
		else if (wrEn)
		begin
			if (selCtrl)
				ctrlReg <= pwdata;
			else if (selIn)
				act[paddr[4:2]] <= pwdata;
			else if (selW0)
				weightH0[paddr[4:2]] <= pwdata;
			else if (selW1)
				weightH1[paddr[4:2]] <= pwdata;
			else if (selWout)
				weightOut[paddr[2]] <= pwdata;
			else if (selB0)
				biasH0 <= pwdata;
			else if (selB1)
				biasH1 <= pwdata;
			else if (selBout)
				biasOut <= pwdata;
		end
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			startHidden <= 1'b0;
			busy <= 1'b0;
			doneFlag <= 1'b0;
			resultReg <= '0;
		end
		else
		begin
			startHidden <= startReq;
			if (startReq)
			begin
				busy <= 1'b1;
				doneFlag <= 1'b0; // sticky until next start
			end
			else if (outDone)
			begin
				busy <= 1'b0;
				doneFlag <= 1'b1;
				resultReg <= outResult;
			end
		end
	end

endmodule

// File: neuron/neuronNode.sv
`timescale 1ns/100ps

module neuronNode
#(
	parameter int NUM_IN = 8
)
(
	input logic clk,
	input logic rstN,
	input logic start,
	input nnPkg::floatT act [NUM_IN],
	input nnPkg::floatT weight [NUM_IN],
	input nnPkg::floatT bias,
	output nnPkg::floatT result,
	output logic done
);
	import nnPkg::*;

	localparam int idxW = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;
	localparam logic [idxW-1:0] lastIdx = idxW'(NUM_IN - 1);

	nodeStateT state;
	logic [idxW-1:0] idx;
	floatT acc;
	floatT product;
	floatT addIn;
	floatT sum;

	fpMul macMul
	(
		.a(act[idx]),
		.b(weight[idx]),
		.p(product)
	);

	// the adder takes the bias in place of a product in the last step
	assign addIn = (state == BIAS) ? bias : product;

	fpAdd macAdd
	(
		.a(acc),
		.b(addIn),
		.s(sum)
	);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= IDLE;
			idx <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (start)
					begin
						state <= MAC;
						idx <= '0;
					end
				end
				MAC:
				begin
					idx <= idx + 1'b1;
					if (idx == lastIdx)
						state <= BIAS;
				end
				BIAS:
					state <= DONE;
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == IDLE && start)
			acc <= '0;
		else if (state == MAC)
			acc <= sum; // one product per cycle

		if (state == BIAS)
		begin
			if (sum.sign)
				result <= '0; // relu
			else
				result <= sum;
		end
	end

	assign done = (state == DONE);

endmodule

// File: design/fpAdd.sv
`timescale 1ns/100ps
`include "nn_consts.svh"

module fpAdd
(
	input nnPkg::floatT a,
	input nnPkg::floatT b,
	output nnPkg::floatT s
);
	import nnPkg::*;

	localparam floatT floatMax = `NN_FLOAT_MAX;

	floatT opBig;
	floatT opSmall;
	logic [7:0] expDiff;
	logic [23:0] bigMant;
	logic [23:0] smallMant;
	logic [24:0] mantSum;
	logic [4:0] lzCount;
	logic lzFound;
	logic [23:0] mantNorm;
	logic signed [9:0] expNorm;

	// order by magnitude and align
	always_comb
	begin
		if ({a.exp, a.mant} >= {b.exp, b.mant})
		begin
			opBig = a;
			opSmall = b;
		end
		else
		begin
			opBig = b;
			opSmall = a;
		end

		expDiff = opBig.exp - opSmall.exp;
		bigMant = (opBig.exp == '0) ? 24'd0 : {1'b1, opBig.mant};
		smallMant = (opSmall.exp == '0) ? 24'd0 : ({1'b1, opSmall.mant} >> expDiff);

		if (opBig.sign == opSmall.sign)
			mantSum = {1'b0, bigMant} + {1'b0, smallMant};
		else
			mantSum = {1'b0, bigMant} - {1'b0, smallMant}; // never negative after ordering
	end

	// normalize and pack
	always_comb
	begin
		lzCount = '0;
		lzFound = 1'b0;
		for (int i = 23; i >= 0; i--)
		begin
			if (!lzFound && mantSum[i])
			begin
				lzFound = 1'b1;
				lzCount = 5'(23 - i);
			end
		end

		if (mantSum[24])
		begin
			mantNorm = mantSum[24:1]; // carry out drops the low bit
			expNorm = $signed({2'b00, opBig.exp}) + 10'sd1;
		end
		else
		begin
			mantNorm = mantSum[23:0] << lzCount;
			expNorm = $signed({2'b00, opBig.exp}) - $signed({5'b00000, lzCount});
		end

		if (mantSum == '0)
		begin
			s = '0; // exact cancellation is +0
		end
		else if (expNorm <= 0)
		begin
			s = '0;
		end
		else if (expNorm >= 255)
		begin
			s.sign = opBig.sign;
			s.exp = floatMax.exp;
			s.mant = floatMax.mant;
		end
		else
		begin
			s.sign = opBig.sign;
			s.exp = expNorm[7:0];
			s.mant = mantNorm[22:0];
		end
	end

endmodule

// File: design/fpMul.sv
`timescale 1ns/100ps
`include "nn_consts.svh"

module fpMul
(
	input nnPkg::floatT a,
	input nnPkg::floatT b,
	output nnPkg::floatT p
);
	import nnPkg::*;

	localparam floatT floatMax = `NN_FLOAT_MAX;
	localparam logic signed [9:0] expBias = `NN_EXP_BIAS;

	logic sign;
	logic [47:0] prod;
	logic signed [9:0] expSum;
	logic signed [9:0] expNorm;
	logic [22:0] mantNorm;

	always_comb
	begin
		sign = a.sign ^ b.sign;
		prod = {1'b1, a.mant} * {1'b1, b.mant};
		expSum = $signed({2'b00, a.exp}) + $signed({2'b00, b.exp}) - expBias;

		// product of two 1.x values is below 4, so one place is enough
		if (prod[47])
		begin
			expNorm = expSum + 10'sd1;
			mantNorm = prod[46:24];
		end
		else
		begin
			expNorm = expSum;
			mantNorm = prod[45:23];
		end

		if (a.exp == '0 || b.exp == '0)
		begin
			p = '0; // zero or subnormal operand
		end
		else if (expNorm <= 0)
		begin
			p = '0; // underflow flushes
		end
		else if (expNorm >= 255)
		begin
			p.sign = sign;
			p.exp = floatMax.exp;
			p.mant = floatMax.mant;
		end
		else
		begin
			p.sign = sign;
			p.exp = expNorm[7:0];
			p.mant = mantNorm;
		end
	end

endmodule

// File: common/nnPkg.sv
`include "nn_consts.svh"

package nnPkg;

	typedef struct packed
	{
		logic sign;
		logic [`NN_EXP_W-1:0] exp; // biased exponent
		logic [`NN_MANT_W-1:0] mant; // fraction without hidden one
	} floatT;

	typedef enum logic [1:0]
	{
		IDLE,
		MAC,
		BIAS,
		DONE
	} nodeStateT;

endpackage

// File: common/nn_consts.svh
`ifndef NN_CONSTS_SVH
`define NN_CONSTS_SVH

// layer geometry
`define NN_INPUTS 8
`define NN_HIDDEN 2

// single precision float fields
`define NN_EXP_W 8
`define NN_MANT_W 23
`define NN_EXP_BIAS 127
`define NN_FLOAT_MAX 32'h7F7F_FFFF

// APB register map
`define NN_ADDR_W 8
`define NN_ADDR_CTRL 8'h00
`define NN_ADDR_STATUS 8'h04
`define NN_ADDR_RESULT 8'h08
`define NN_ADDR_IN 8'h40
`define NN_ADDR_W0 8'h80
`define NN_ADDR_W1 8'hA0
`define NN_ADDR_WOUT 8'hC0
`define NN_ADDR_B0 8'hC8
`define NN_ADDR_B1 8'hCC
`define NN_ADDR_BOUT 8'hD0

`endif
